//--- alloc_consts.svh
`ifndef ALLOC_CONSTS_SVH
`define ALLOC_CONSTS_SVH

// router geometry
`define NUM_PORTS 5
`define NUM_VCS   4

// a port never routes back to itself, so one destination bit per other port
`define NUM_DESTS (`NUM_PORTS - 1)

`endif

//--- noc_alloc_pkg.sv
`include "alloc_consts.svh"

package noc_alloc_pkg;

    typedef logic [`NUM_VCS-1:0]   vc_mask_t;   // one bit per vc of a port
    typedef logic [`NUM_DESTS-1:0] dest_t;      // one-hot over the other ports
    typedef logic [`NUM_PORTS-1:0] port_mask_t; // one bit per port

    // one entry per port
    typedef vc_mask_t [`NUM_PORTS-1:0] port_vc_t;
    typedef dest_t    [`NUM_PORTS-1:0] port_dest_t;

    // one entry per input vc, flat index is port * NUM_VCS + vc
    typedef dest_t    [`NUM_PORTS*`NUM_VCS-1:0] vc_dest_t;
    typedef vc_mask_t [`NUM_PORTS*`NUM_VCS-1:0] vc_ovc_t;

    // dest bit k of input port i addresses output k below i, k+1 otherwise

endpackage

//--- sw_stage_if.sv
`timescale 1ns/1ps

interface sw_stage_if;
    import noc_alloc_pkg::*;

    port_vc_t   first_grant;     // input arbiter winners
    port_vc_t   ivc_granted;     // winners that also won their output
    port_dest_t granted_dest;    // granted output per input port
    port_mask_t inport_granted;
    port_mask_t outport_granted;

    // the allocation stage drives the results
    modport stage (
        output first_grant,
        output ivc_granted,
        output granted_dest,
        output inport_granted,
        output outport_granted
    );

    // merge logic only looks at them
    modport merge (
        input first_grant,
        input ivc_granted,
        input granted_dest,
        input inport_granted,
        input outport_granted
    );

endinterface

//--- rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] request,
    input  logic             advance,
    output logic [width-1:0] grant
);
    localparam int idx_w = (width > 1) ? $clog2(width) : 1;

    logic [idx_w-1:0] ptr;        // index with the highest priority
    logic [idx_w-1:0] grant_idx;
    logic [idx_w-1:0] next_ptr;

    // walk down from the farthest offset so the nearest requester wins
    always_comb begin
        int idx;
        idx       = 0;
        grant     = '0;
        grant_idx = '0;
        for (int off = width - 1; off >= 0; off--) begin
            idx = (int'(ptr) + off) % width;
            if (request[idx]) begin
                grant      = '0;
                grant[idx] = 1'b1;
                grant_idx  = idx_w'(idx);
            end
        end
    end

    // one past the winner, wrapping at the top
    assign next_ptr = (grant_idx == idx_w'(width - 1)) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && (|grant)) begin
            ptr <= next_ptr;
        end
    end

    // at most one winner and only among the requesters
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant & ~request) == '0));

endmodule

//--- sw_alloc_stage.sv
`timescale 1ns/1ps
`include "alloc_consts.svh"

module sw_alloc_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  noc_alloc_pkg::port_vc_t request,
    input  noc_alloc_pkg::vc_dest_t dest_port,
    sw_stage_if.stage               results
);
    import noc_alloc_pkg::*;

    vc_mask_t   in_grant [`NUM_PORTS];  // vc winner per input port
    dest_t      win_dest [`NUM_PORTS];  // destination of that winner
    dest_t      out_req  [`NUM_PORTS];  // per output, indexed by input with self skipped
    dest_t      out_gnt  [`NUM_PORTS];
    port_dest_t granted_dest;
    port_mask_t inport_granted;
    port_mask_t outport_granted;

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        // first level, one vc per input port
        rr_arbiter #(.width(`NUM_VCS)) in_arb (
            .clk     (clk),
            .rst     (rst),
            .request (request[i]),
            .advance (inport_granted[i]),
            .grant   (in_grant[i])
        );

        // second level, one input per output port
        rr_arbiter #(.width(`NUM_DESTS)) out_arb (
            .clk     (clk),
            .rst     (rst),
            .request (out_req[i]),
            .advance (outport_granted[i]),
            .grant   (out_gnt[i])
        );
    end

    // route each winner's destination to the output arbiters
    always_comb begin
        int o;
        o = 0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            win_dest[i] = '0;
            out_req[i]  = '0;
        end
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int j = 0; j < `NUM_VCS; j++) begin
                if (in_grant[i][j]) begin
                    win_dest[i] = win_dest[i] | dest_port[i*`NUM_VCS + j];
                end
            end
            for (int k = 0; k < `NUM_DESTS; k++) begin
                o = (k < i) ? k : k + 1;                  // skip own port
                out_req[o][(i < o) ? i : i - 1] = win_dest[i][k];
            end
        end
    end

    // map output grants back to the inputs
    always_comb begin
        int o;
        o = 0;
        granted_dest = '0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int k = 0; k < `NUM_DESTS; k++) begin
                o = (k < i) ? k : k + 1;
                granted_dest[i][k] = out_gnt[o][(i < o) ? i : i - 1];
            end
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            inport_granted[p]  = |granted_dest[p];
            outport_granted[p] = |out_gnt[p];
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            results.first_grant[i] = in_grant[i];
            results.ivc_granted[i] = inport_granted[i] ? in_grant[i] : '0; // lost at output
        end
    end

    assign results.granted_dest    = granted_dest;
    assign results.inport_granted  = inport_granted;
    assign results.outport_granted = outport_granted;

endmodule

//--- spec_switch_allocator.sv
`timescale 1ns/1ps
`include "alloc_consts.svh"

module spec_switch_allocator (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_alloc_pkg::port_vc_t   ivc_request,
    input  noc_alloc_pkg::port_vc_t   ovc_is_assigned,
    input  noc_alloc_pkg::port_vc_t   assigned_ovc_not_full,
    input  noc_alloc_pkg::vc_ovc_t    candidate_ovc,
    input  noc_alloc_pkg::vc_dest_t   dest_port,
    output noc_alloc_pkg::port_vc_t   ivc_sw_grant,
    output noc_alloc_pkg::port_dest_t granted_dest_port,
    output noc_alloc_pkg::port_mask_t any_sw_grant,
    output noc_alloc_pkg::port_vc_t   spec_first_grant,
    output noc_alloc_pkg::port_dest_t spec_granted_dest,
    output noc_alloc_pkg::port_mask_t spec_grant_valid
);
    import noc_alloc_pkg::*;

    sw_stage_if ns_res ();
    sw_stage_if sp_res ();

    port_vc_t   has_cand;        // at least one free candidate ovc
    port_vc_t   nonspec_req;
    port_vc_t   spec_req;
    port_dest_t dest_blocked;    // outputs held by the non-spec path
    port_dest_t spec_accepted;
    port_vc_t   spec_ivc_grant;
    port_mask_t spec_out_taken;

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int j = 0; j < `NUM_VCS; j++) begin
                has_cand[i][j] = |candidate_ovc[i*`NUM_VCS + j];
            end
        end
    end

    assign nonspec_req = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
    assign spec_req    = ivc_request & ~ovc_is_assigned & has_cand;

    sw_alloc_stage nonspec_stage (
        .clk       (clk),
        .rst       (rst),
        .request   (nonspec_req),
        .dest_port (dest_port),
        .results   (ns_res.stage)
    );

    sw_alloc_stage spec_stage (
        .clk       (clk),
        .rst       (rst),
        .request   (spec_req),
        .dest_port (dest_port),
        .results   (sp_res.stage)
    );

    // non-spec wins both the input and the output side
    always_comb begin
        int o;
        o = 0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int k = 0; k < `NUM_DESTS; k++) begin
                o = (k < i) ? k : k + 1;
                dest_blocked[i][k] = ns_res.outport_granted[o];
            end
            if (sp_res.inport_granted[i] && !ns_res.inport_granted[i]) begin
                spec_accepted[i] = sp_res.granted_dest[i] & ~dest_blocked[i];
            end else begin
                spec_accepted[i] = '0;
            end
            spec_grant_valid[i] = |spec_accepted[i];
            spec_ivc_grant[i]   = spec_grant_valid[i] ? sp_res.ivc_granted[i] : '0;
        end
    end

    always_comb begin
        int o;
        o = 0;
        spec_out_taken = '0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int k = 0; k < `NUM_DESTS; k++) begin
                o = (k < i) ? k : k + 1;
                if (spec_accepted[i][k]) begin
                    spec_out_taken[o] = 1'b1;
                end
            end
        end
    end

    assign ivc_sw_grant      = ns_res.ivc_granted | spec_ivc_grant;
    assign granted_dest_port = ns_res.granted_dest | spec_accepted;
    assign any_sw_grant      = ns_res.inport_granted | spec_grant_valid;
    assign spec_first_grant  = sp_res.first_grant;   // gated later by spec_grant_valid
    assign spec_granted_dest = spec_accepted;

    // an input port carries a single grant from either path
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_chk
        a_one_path: assert property (@(posedge clk) disable iff (rst)
            $onehot0(ivc_sw_grant[i]) && $onehot0(granted_dest_port[i]));
    end

    // accepted spec outputs were won by the spec stage and are free of non-spec
    a_out_excl: assert property (@(posedge clk) disable iff (rst)
        ((spec_out_taken & ns_res.outport_granted) == '0) &&
        ((spec_out_taken & ~sp_res.outport_granted) == '0));

endmodule

//--- vc_alloc_stage.sv
`timescale 1ns/1ps
`include "alloc_consts.svh"

module vc_alloc_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_alloc_pkg::vc_ovc_t    candidate_ovc,
    input  noc_alloc_pkg::port_vc_t   spec_first_grant,
    input  noc_alloc_pkg::port_dest_t spec_granted_dest,
    input  noc_alloc_pkg::port_mask_t spec_grant_valid,
    output noc_alloc_pkg::port_vc_t   ivc_ovc_grant,
    output noc_alloc_pkg::vc_ovc_t    granted_ovc_num,
    output noc_alloc_pkg::port_vc_t   ovc_allocated
);
    import noc_alloc_pkg::*;

    vc_mask_t ovc_req [`NUM_PORTS];   // candidates of the spec winner
    vc_mask_t ovc_gnt [`NUM_PORTS];   // chosen output vc
    logic     alloc_clash;

    // select candidates by the first level winner
    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            ovc_req[i] = '0;
            for (int j = 0; j < `NUM_VCS; j++) begin
                if (spec_first_grant[i][j]) begin
                    ovc_req[i] = ovc_req[i] | candidate_ovc[i*`NUM_VCS + j];
                end
            end
        end
    end

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        rr_arbiter #(.width(`NUM_VCS)) ovc_arb (
            .clk     (clk),
            .rst     (rst),
            .request (ovc_req[i]),
            .advance (spec_grant_valid[i]),   // only a used choice moves on
            .grant   (ovc_gnt[i])
        );
    end

    // report the winner vc and its output vc
    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            ivc_ovc_grant[i] = spec_grant_valid[i] ? spec_first_grant[i] : '0;
            for (int j = 0; j < `NUM_VCS; j++) begin
                if (spec_grant_valid[i] && spec_first_grant[i][j]) begin
                    granted_ovc_num[i*`NUM_VCS + j] = ovc_gnt[i];
                end else begin
                    granted_ovc_num[i*`NUM_VCS + j] = '0;
                end
            end
        end
    end

    // mark the output vc at the granted output port
    always_comb begin
        int o;
        o             = 0;
        ovc_allocated = '0;
        alloc_clash   = 1'b0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int k = 0; k < `NUM_DESTS; k++) begin
                if (spec_grant_valid[i] && spec_granted_dest[i][k]) begin
                    o = (k < i) ? k : k + 1;
                    alloc_clash      = alloc_clash | (|(ovc_allocated[o] & ovc_gnt[i]));
                    ovc_allocated[o] = ovc_allocated[o] | ovc_gnt[i];
                end
            end
        end
    end

    // relies on the switch stage granting each output to one input
    a_ovc_unique: assert property (@(posedge clk) disable iff (rst) !alloc_clash);

endmodule

//--- comb_spec_allocator.sv
`timescale 1ns/1ps

module comb_spec_allocator (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_alloc_pkg::port_vc_t   ivc_request,
    input  noc_alloc_pkg::port_vc_t   ovc_is_assigned,
    input  noc_alloc_pkg::port_vc_t   assigned_ovc_not_full,
    input  noc_alloc_pkg::vc_dest_t   dest_port,
    input  noc_alloc_pkg::vc_ovc_t    candidate_ovc,
    output noc_alloc_pkg::port_vc_t   ivc_sw_grant,
    output noc_alloc_pkg::port_dest_t granted_dest_port,
    output noc_alloc_pkg::port_mask_t any_sw_grant,
    output noc_alloc_pkg::port_vc_t   ivc_ovc_grant,
    output noc_alloc_pkg::vc_ovc_t    granted_ovc_num,
    output noc_alloc_pkg::port_vc_t   ovc_allocated
);
    import noc_alloc_pkg::*;

    // speculative winners handed from switch to vc allocation
    port_vc_t   spec_first_grant;
    port_dest_t spec_granted_dest;
    port_mask_t spec_grant_valid;

    spec_switch_allocator sw_alloc (
        .clk                   (clk),
        .rst                   (rst),
        .ivc_request           (ivc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .candidate_ovc         (candidate_ovc),
        .dest_port             (dest_port),
        .ivc_sw_grant          (ivc_sw_grant),
        .granted_dest_port     (granted_dest_port),
        .any_sw_grant          (any_sw_grant),
        .spec_first_grant      (spec_first_grant),
        .spec_granted_dest     (spec_granted_dest),
        .spec_grant_valid      (spec_grant_valid)
    );

    vc_alloc_stage vc_alloc (
        .clk               (clk),
        .rst               (rst),
        .candidate_ovc     (candidate_ovc),
        .spec_first_grant  (spec_first_grant),
        .spec_granted_dest (spec_granted_dest),
        .spec_grant_valid  (spec_grant_valid),
        .ivc_ovc_grant     (ivc_ovc_grant),
        .granted_ovc_num   (granted_ovc_num),
        .ovc_allocated     (ovc_allocated)
    );

endmodule

//--- tb_comb_spec_allocator.sv
`timescale 1ns/1ps
`include "alloc_consts.svh"

module tb_comb_spec_allocator;
    import noc_alloc_pkg::*;

    localparam int clk_period    = 100;
    localparam int random_cycles = 600;
    localparam int cycle_limit   = 1000;  // about 630 cycles of reset and tests plus margin

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    port_vc_t    ivc_request           = '0;
    port_vc_t    ovc_is_assigned       = '0;
    port_vc_t    assigned_ovc_not_full = '0;
    vc_dest_t    dest_port             = '0;
    vc_ovc_t     candidate_ovc         = '0;
    port_vc_t    ivc_sw_grant;
    port_dest_t  granted_dest_port;
    port_mask_t  any_sw_grant;
    port_vc_t    ivc_ovc_grant;
    vc_ovc_t     granted_ovc_num;
    port_vc_t    ovc_allocated;
    int          cycle_count = 0;
    logic [15:0] lfsr        = 16'd59;
    int          in_ptr  [2][`NUM_PORTS];  // index 0 for the non-spec stage and 1 for spec
    int          out_ptr [2][`NUM_PORTS];
    int          vc_ptr  [`NUM_PORTS];

    comb_spec_allocator uut (.*);

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int b = 0; b < n; b++) v = {v[6:0], rand_bit()};
        return v;
    endfunction

    // first requester at or after the pointer or -1 for none
    function automatic int rr_pick(input logic [7:0] req, input int width, input int ptr);
        int idx;
        for (int off = 0; off < width; off++) begin
            idx = (ptr + off) % width;
            if (req[idx]) return idx;
        end
        return -1;
    endfunction

    function automatic int out_of(input int i, input int k);
        return (k < i) ? k : k + 1;     // dest bit k of input i
    endfunction

    function automatic int slot(input int i, input int o);
        return (i < o) ? i : i - 1;     // input i as seen from output o
    endfunction

    // separable input-first allocation that moves its pointers as it decides
    function automatic void stage_model(input int s, input port_vc_t req,
            output port_vc_t first, output port_vc_t won, output port_dest_t gdest,
            output port_mask_t in_gr, output port_mask_t out_gr);
        int    w [`NUM_PORTS];
        int    g [`NUM_PORTS];
        dest_t out_req [`NUM_PORTS];
        first  = '0;
        won    = '0;
        gdest  = '0;
        in_gr  = '0;
        out_gr = '0;
        foreach (out_req[p]) out_req[p] = '0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            w[i] = rr_pick(req[i], `NUM_VCS, in_ptr[s][i]);
            if (w[i] >= 0) begin
                first[i][w[i]] = 1'b1;
                for (int k = 0; k < `NUM_DESTS; k++) begin
                    out_req[out_of(i, k)][slot(i, out_of(i, k))] =
                        dest_port[i*`NUM_VCS + w[i]][k];
                end
            end
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            g[p] = rr_pick(out_req[p], `NUM_DESTS, out_ptr[s][p]);
            if (g[p] >= 0) begin
                out_gr[p]     = 1'b1;
                out_ptr[s][p] = (g[p] + 1) % `NUM_DESTS;
            end
        end
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int k = 0; k < `NUM_DESTS; k++) begin
                gdest[i][k] = (g[out_of(i, k)] == slot(i, out_of(i, k)));
            end
            in_gr[i] = |gdest[i];
            if (in_gr[i]) begin
                won[i]       = first[i];
                in_ptr[s][i] = (w[i] + 1) % `NUM_VCS;
            end
        end
    endfunction

    // expected outputs for the current inputs with the model pointers moved on
    function automatic void reference_alloc(output port_vc_t sw_gnt, output port_dest_t gdest,
            output port_mask_t any_gnt, output port_vc_t ovc_ivc, output vc_ovc_t ovc_num,
            output port_vc_t alloc);
        port_vc_t   ns_req, sp_req, ns_first, sp_first, ns_won, sp_won;
        port_dest_t ns_dest, sp_dest;
        port_mask_t ns_in, sp_in, ns_out, sp_out;
        dest_t      spec_dest;
        vc_mask_t   cand;
        int         v;
        ns_req = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            for (int j = 0; j < `NUM_VCS; j++) begin
                sp_req[i][j] = ivc_request[i][j] & ~ovc_is_assigned[i][j]
                             & (|candidate_ovc[i*`NUM_VCS + j]);
            end
        end
        stage_model(0, ns_req, ns_first, ns_won, ns_dest, ns_in, ns_out);
        stage_model(1, sp_req, sp_first, sp_won, sp_dest, sp_in, sp_out);
        sw_gnt  = ns_won;
        gdest   = ns_dest;
        any_gnt = ns_in;
        ovc_ivc = '0;
        ovc_num = '0;
        alloc   = '0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            spec_dest = '0;
            if (sp_in[i] && !ns_in[i]) begin
                for (int k = 0; k < `NUM_DESTS; k++) begin
                    spec_dest[k] = sp_dest[i][k] && !ns_out[out_of(i, k)];
                end
            end
            if (|spec_dest) begin
                sw_gnt[i]  = sp_won[i];
                gdest[i]   = spec_dest;
                any_gnt[i] = 1'b1;
                ovc_ivc[i] = sp_first[i];
                cand       = '0;
                for (int j = 0; j < `NUM_VCS; j++) begin
                    if (sp_first[i][j]) cand = candidate_ovc[i*`NUM_VCS + j];
                end
                v         = rr_pick(cand, `NUM_VCS, vc_ptr[i]);  // never empty here
                vc_ptr[i] = (v + 1) % `NUM_VCS;
                for (int j = 0; j < `NUM_VCS; j++) begin
                    if (sp_first[i][j]) ovc_num[i*`NUM_VCS + j][v] = 1'b1;
                end
                for (int k = 0; k < `NUM_DESTS; k++) begin
                    if (spec_dest[k]) alloc[out_of(i, k)][v] = 1'b1;
                end
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [191:0] got,
            input logic [191:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // wait for the falling edge and drop every request
    task automatic next_cycle();
        @(negedge clk);
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        dest_port             = '0;
        candidate_ovc         = '0;
    endtask

    task automatic set_vc(input int p, input int v, input logic assigned, input logic not_full,
            input dest_t dest, input vc_mask_t cand);
        ivc_request[p][v]             = 1'b1;
        ovc_is_assigned[p][v]         = assigned;
        assigned_ovc_not_full[p][v]   = not_full;
        dest_port[p*`NUM_VCS + v]     = dest;
        candidate_ovc[p*`NUM_VCS + v] = cand;
    endtask

    always @(posedge clk) begin : compare
        port_vc_t   e_sw_grant, e_ovc_grant, e_alloc;
        port_dest_t e_dest;
        port_mask_t e_any;
        vc_ovc_t    e_ovc_num;
        if (rst) begin
            foreach (in_ptr[s, p]) begin
                in_ptr[s][p]  = 0;
                out_ptr[s][p] = 0;
            end
            foreach (vc_ptr[p]) vc_ptr[p] = 0;
        end else begin
            reference_alloc(e_sw_grant, e_dest, e_any, e_ovc_grant, e_ovc_num, e_alloc);
            check_value("ivc_sw_grant", ivc_sw_grant, e_sw_grant);
            check_value("granted_dest_port", granted_dest_port, e_dest);
            check_value("any_sw_grant", any_sw_grant, e_any);
            check_value("ivc_ovc_grant", ivc_ovc_grant, e_ovc_grant);
            check_value("granted_ovc_num", granted_ovc_num, e_ovc_num);
            check_value("ovc_allocated", ovc_allocated, e_alloc);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        vc_mask_t exp_ovc;
        next_cycle();
        repeat (7) @(negedge clk);
        rst = 1'b0;                                    // 8 cycles of reset
        #(clk_period / 4);
        check_value("idle outputs", {ivc_sw_grant, granted_dest_port, any_sw_grant,
            ivc_ovc_grant, granted_ovc_num, ovc_allocated}, '0);
        for (int n = 0; n < `NUM_VCS; n++) begin       // port 0 vcs to output 1 in turn
            next_cycle();
            for (int v = 0; v < `NUM_VCS; v++) set_vc(0, v, 1'b1, 1'b1, 4'b0001, '0);
            #(clk_period / 4);
            check_value("round robin vc", ivc_sw_grant[0], 1 << n);
            check_value("round robin port", any_sw_grant, 5'b00001);
        end
        repeat (3) begin
            next_cycle();
            set_vc(3, 2, 1'b1, 1'b0, 4'b0010, '0);     // its output vc is full
            #(clk_period / 4);
            check_value("full ovc masked", any_sw_grant, '0);
        end
        next_cycle();
        set_vc(0, 0, 1'b1, 1'b1, 4'b0001, '0);         // same input port on both paths
        set_vc(0, 1, 1'b0, 1'b1, 4'b0010, 4'b0011);
        #(clk_period / 4);
        check_value("input clash grant", {any_sw_grant, ivc_sw_grant[0]}, {5'b00001, 4'b0001});
        check_value("input clash spec", {ivc_ovc_grant, ovc_allocated}, '0);
        next_cycle();
        set_vc(0, 0, 1'b1, 1'b1, 4'b0010, '0);         // both want output 2
        set_vc(1, 3, 1'b0, 1'b1, 4'b0010, 4'b0100);
        #(clk_period / 4);
        check_value("output clash grant", any_sw_grant, 5'b00001);
        check_value("output clash spec", {ivc_ovc_grant, granted_ovc_num}, '0);
        for (int n = 0; n < 3; n++) begin              // spec port 2 vc 3 to output 4
            next_cycle();
            set_vc(2, 3, 1'b0, 1'b1, 4'b1000, 4'b1010);
            #(clk_period / 4);
            exp_ovc = (n == 1) ? 4'b1000 : 4'b0010;
            check_value("vc alloc ovc", granted_ovc_num[2*`NUM_VCS + 3], exp_ovc);
            check_value("vc alloc ivc", ivc_ovc_grant[2], 4'b1000);
            check_value("vc alloc map", ovc_allocated, {exp_ovc, 16'h0});
        end
        repeat (random_cycles) begin
            next_cycle();
            for (int p = 0; p < `NUM_PORTS; p++) begin
                for (int v = 0; v < `NUM_VCS; v++) begin
                    if (rand_bit()) begin
                        set_vc(p, v, rand_bit(), rand_bit() | rand_bit(),
                            dest_t'(4'b0001 << rand_bits(2)), vc_mask_t'(rand_bits(4)));
                    end
                end
            end
        end
        next_cycle();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
noc_alloc_pkg.sv
sw_stage_if.sv
rr_arbiter.sv
sw_alloc_stage.sv
spec_switch_allocator.sv
vc_alloc_stage.sv
comb_spec_allocator.sv
tb_comb_spec_allocator.sv

//--- Makefile
SIM      = verilator
TOP      = tb_comb_spec_allocator
FILELIST = files.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
